//--- verif/mem_test_golden.txt
# name seed fault_en fault_addr wait_density expect_fail
# seed and fault_addr in hex, wait_density in sixteenths, expect_fail 1 for a failing run
clean_d0      0123456789abcdef 0 00 0  0
clean_d4      fedcba9876543210 0 00 4  0
clean_d8      00000000deadbeef 0 00 8  0
clean_d15     a5a5a5a55a5a5a5a 0 00 15 0
clean_wrap    ffffffffffffffff 0 00 12 0
clean_zero    0000000000000000 0 00 6  0
fault_a00     1357924680acebdf 1 00 3  1
fault_a17     0f1e2d3c4b5a6978 1 17 8  1
fault_a2a     8badf00dcafebabe 1 2a 0  1
fault_a3f     7766554433221100 1 3f 15 1

//--- mem_test_top.f
+incdir+common
common/mem_test_pkg.sv
src/start_trigger.sv
sequencer/pattern_gen.sv
src/readback_checker.sv
sequencer/test_sequencer.sv
src/mem_test_top.sv
verif/avalon_mem_model.sv
verif/tb_mem_test.sv

//--- Bender.yml
package:
  name: mem_test

sources:
  - include_dirs:
      - common
    files:
      - common/mem_test_pkg.sv
      - src/start_trigger.sv
      - sequencer/pattern_gen.sv
      - src/readback_checker.sv
      - sequencer/test_sequencer.sv
      - src/mem_test_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - verif/avalon_mem_model.sv
      - verif/tb_mem_test.sv

//--- verif/tb_mem_test.sv
`include "mem_test_defines.svh"

module tb_mem_test;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int AW        = `MT_ADDR_W;
	localparam int WORDS     = 2 ** AW;
	localparam int RUN_LIMIT = WORDS * 2 * (`MT_SETTLE_CYCLES + 200); // generous per word

	logic iCLK = 1'b0;
	logic arst_n, button, local_init_done;
	logic [63:0] pattern_seed;
	logic avl_waitrequest_n, avl_readdatavalid, avl_read, avl_write, avl_burstbegin;
	logic [mem_test_pkg::DATA_W-1:0] avl_readdata, avl_writedata;
	logic [AW-1:0] avl_address, fail_address, fault_addr;
	logic drv_status_pass, drv_status_fail, drv_status_test_complete;
	mem_test_pkg::test_state_e c_state;
	logic [3:0] wait_density;
	logic fault_en;

	string test_name;
	logic [63:0] run_seed;
	int g_fault_en, g_density, g_expect_fail;
	logic [AW-1:0] g_fault_addr;
	int errors = 0;
	int checks = 0;
	int tests  = 0;
	int exp_write_addr, exp_read_addr; // next address expected, also the counts
	logic held, held_wr, held_rd; // last cycle stalled a request
	logic [AW-1:0] held_addr;
	logic [mem_test_pkg::DATA_W-1:0] held_data;

	always #4 iCLK = ~iCLK; // 8 ns period

	mem_test_top DUT (.*);

	avalon_mem_model u_mem (
		.iCLK(iCLK), .arst_n(arst_n), .avl_address(avl_address),
		.avl_writedata(avl_writedata), .avl_write(avl_write), .avl_read(avl_read),
		.wait_density(wait_density), .fault_en(fault_en), .fault_addr(fault_addr),
		.avl_waitrequest_n(avl_waitrequest_n), .avl_readdatavalid(avl_readdatavalid),
		.avl_readdata(avl_readdata)
	);

	task automatic check_value(input string what, input logic [127:0] expected,
			input logic [127:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("error %0s %0s: expected %h actual %h", test_name, what, expected, actual);
		end
	endtask

	// pattern rule, seed and address to the 128 bit word
	function automatic logic [127:0] expected_word(input logic [63:0] s, input logic [AW-1:0] a);
		logic [63:0] mix;
		logic [63:0] rot;
		logic [63:0] sum;
		logic [7:0]  tag;
		mix = s + 64'(a);
		rot = {mix[31:0], mix[63:32]} ^ s;
		sum = rot + s;
		tag = rot[7:0] + sum[7:0];
		return {sum[61:6], tag, sum};
	endfunction

	// ==============================
	// bus monitor
	// ==============================
	always @(posedge iCLK) begin
		if (arst_n) begin
			check_value("write and read together", 0, avl_write & avl_read);
			check_value("burst begin raised", 0, avl_burstbegin);
			if (held) begin // stalled last cycle, nothing may move
				check_value("request dropped under wait", {held_wr, held_rd}, {avl_write, avl_read});
				check_value("address moved under wait", held_addr, avl_address);
				if (held_wr) check_value("data moved under wait", held_data, avl_writedata);
			end
			held      = (avl_write | avl_read) & ~avl_waitrequest_n;
			held_wr   = avl_write;
			held_rd   = avl_read;
			held_addr = avl_address;
			held_data = avl_writedata;
			if (avl_write && avl_waitrequest_n) begin // accepted write
				check_value("write address", exp_write_addr, avl_address);
				check_value("write data", expected_word(run_seed, avl_address), avl_writedata);
				exp_write_addr++;
			end
			if (avl_read && avl_waitrequest_n) begin // accepted read
				check_value("read address", exp_read_addr, avl_address);
				if (fault_en) check_value("read above fault address", 1, avl_address <= fault_addr);
				exp_read_addr++;
			end
		end else begin
			held = 1'b0;
		end
	end

	task automatic press_button();
		button = 1'b0; // held long enough for the synchronizer
		repeat (4) @(negedge iCLK);
		button = 1'b1;
		@(negedge iCLK);
	endtask

	// ==============================
	// one golden line
	// ==============================
	task automatic run_test();
		bit seen;
		int n;
		logic [2:0] status;
		@(negedge iCLK);
		arst_n          = 1'b0;
		button          = 1'b1;
		local_init_done = 1'b0;
		pattern_seed    = run_seed;
		wait_density    = g_density[3:0];
		fault_en        = (g_fault_en != 0);
		fault_addr      = g_fault_addr;
		exp_write_addr  = 0;
		exp_read_addr   = 0;
		repeat (5) @(negedge iCLK);
		arst_n = 1'b1;
		press_button(); // controller not ready yet
		for (n = 0; n < 20; n++) begin
			@(negedge iCLK);
			check_value("state without init", mem_test_pkg::idle, c_state);
			check_value("write without init", 0, avl_write);
		end
		local_init_done = 1'b1;
		press_button();
		seen = 1'b0;
		for (n = 0; n < `MT_SETTLE_CYCLES + 16 && !seen; n++) begin
			@(negedge iCLK);
			seen = avl_write;
		end
		if (!seen) begin
			errors++;
			$display("timeout in %0s: no write started after the button press", test_name);
			return;
		end
		seen = 1'b0;
		for (n = 0; n < RUN_LIMIT && !seen; n++) begin
			@(negedge iCLK);
			seen = drv_status_test_complete;
		end
		if (!seen) begin
			errors++;
			$display("timeout in %0s: the run never reported complete", test_name);
			return;
		end
		check_value("pass flag", g_expect_fail == 0, drv_status_pass);
		check_value("fail flag", g_expect_fail != 0, drv_status_fail);
		check_value("writes accepted", WORDS, exp_write_addr);
		if (g_expect_fail != 0) begin
			check_value("fail address", g_fault_addr, fail_address);
			check_value("reads accepted", int'(g_fault_addr) + 1, exp_read_addr);
		end else begin
			check_value("reads accepted", WORDS, exp_read_addr);
		end
		status = {drv_status_pass, drv_status_fail, drv_status_test_complete};
		press_button(); // must not restart
		for (n = 0; n < 50; n++) begin
			@(negedge iCLK);
			check_value("sticky status", status,
				{drv_status_pass, drv_status_fail, drv_status_test_complete});
		end
	endtask

	initial begin
		int fd;
		int fields;
		logic [8*200-1:0] line;
		arst_n          = 1'b0;
		button          = 1'b1;
		local_init_done = 1'b0;
		pattern_seed    = '0;
		wait_density    = '0;
		fault_en        = 1'b0;
		fault_addr      = '0;
		held            = 1'b0;
		fd = $fopen("verif/mem_test_golden.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("could not open the golden file");
		end else begin
			while (!$feof(fd)) begin
				line = '0;
				if ($fgets(line, fd) != 0) begin
					fields = $sscanf(line, "%s %h %d %h %d %d", test_name, run_seed,
						g_fault_en, g_fault_addr, g_density, g_expect_fail);
					if (fields == 6) begin // comments and blank lines fall through
						tests++;
						$display("running %0s", test_name);
						run_test();
					end
				end
			end
			$fclose(fd);
		end
		if (tests == 0) begin
			errors++;
			$display("no test lines found in the golden file");
		end
		$display("tests %0d checks %0d errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- verif/avalon_mem_model.sv
`include "mem_test_defines.svh"

module avalon_mem_model (
	input  logic                            iCLK,
	input  logic                            arst_n,
	input  logic [`MT_ADDR_W-1:0]           avl_address,
	input  logic [mem_test_pkg::DATA_W-1:0] avl_writedata,
	input  logic                            avl_write,
	input  logic                            avl_read,
	input  logic [3:0]                      wait_density, // stall chance in sixteenths
	input  logic                            fault_en,     // arm the one shot fault
	input  logic [`MT_ADDR_W-1:0]           fault_addr,
	output logic                            avl_waitrequest_n,
	output logic                            avl_readdatavalid,
	output logic [mem_test_pkg::DATA_W-1:0] avl_readdata
);
	timeunit 1ns;
	timeprecision 1ps;

	logic [mem_test_pkg::DATA_W-1:0] mem [0:2**`MT_ADDR_W-1]; // backing store
	logic [31:0]                     lfsr_state = 32'hc3b4_bd22;
	logic [`MT_ADDR_W-1:0]           rd_addr;   // address of the pending read
	int                              rd_issued; // reads accepted
	int                              rd_done;   // reads returned
	logic [7:0]                      rd_delay;  // latency drawn for this read
	logic [7:0]                      lat_cnt;
	logic                            lat_set;   // latency already drawn
	logic                            fault_done; // fault fires only once

	// galois lfsr, one step per bit handed out
	function automatic logic [7:0] draw_bits(input int n);
		logic [7:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = {1'b0, lfsr_state[31:1]} ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
			val        = {val[6:0], lfsr_state[0]};
		end
		return val;
	endfunction

	// ==============================
	// accept on rising edge
	// ==============================
	always @(posedge iCLK or negedge arst_n) begin
		if (!arst_n) begin
			rd_issued <= 0;
		end else if (avl_waitrequest_n) begin
			if (avl_write) begin
				mem[avl_address] <= avl_writedata; // write completes this cycle
			end
			if (avl_read) begin
				rd_addr   <= avl_address;
				rd_issued <= rd_issued + 1;
			end
		end
	end

	// ==============================
	// respond on falling edge
	// ==============================
	always @(negedge iCLK or negedge arst_n) begin
		if (!arst_n) begin
			avl_waitrequest_n <= 1'b0;
			avl_readdatavalid <= 1'b0;
			avl_readdata      <= '0;
			rd_done    = 0;
			lat_set    = 1'b0;
			lat_cnt    = '0;
			fault_done = 1'b0;
		end else begin
			avl_readdatavalid <= 1'b0;
			if (rd_issued != rd_done) begin
				if (!lat_set) begin
					rd_delay = draw_bits(3); // 0 to 7 cycles
					lat_cnt  = '0;
					lat_set  = 1'b1;
				end
				if (lat_cnt == rd_delay) begin
					avl_readdatavalid <= 1'b1;
					if (fault_en && !fault_done && rd_addr == fault_addr) begin
						avl_readdata <= mem[rd_addr] ^ 128'd1; // stored bit 0 seen flipped
						fault_done = 1'b1;
					end else begin
						avl_readdata <= mem[rd_addr];
					end
					rd_done = rd_done + 1;
					lat_set = 1'b0;
				end else begin
					lat_cnt = lat_cnt + 1'b1;
				end
			end
			avl_waitrequest_n <= (draw_bits(4) >= wait_density); // stall below density
		end
	end

endmodule

//--- src/mem_test_top.sv
`include "mem_test_defines.svh"

module mem_test_top (
	input  logic                            iCLK,
	input  logic                            arst_n,
	input  logic                            button,            // push button, low when pressed
	input  logic                            local_init_done,   // controller ready
	input  logic [63:0]                     pattern_seed,
	input  logic                            avl_waitrequest_n, // avalon master port
	input  logic                            avl_readdatavalid,
	input  logic [mem_test_pkg::DATA_W-1:0] avl_readdata,
	output logic [`MT_ADDR_W-1:0]           avl_address,
	output logic [mem_test_pkg::DATA_W-1:0] avl_writedata,
	output logic                            avl_read,
	output logic                            avl_write,
	output logic                            avl_burstbegin,    // single transfers only
	output logic                            drv_status_pass,
	output logic                            drv_status_fail,
	output logic                            drv_status_test_complete,
	output mem_test_pkg::test_state_e       c_state,
	output logic [`MT_ADDR_W-1:0]           fail_address
);

	logic                            start;       // trigger to fsm
	logic [63:0]                     seed;        // run seed to pattern_gen
	logic [mem_test_pkg::DATA_W-1:0] pattern;     // expected word
	logic                            match_valid; // checker verdict strobe
	logic                            match;

	// ==============================
	// stages
	// ==============================
	start_trigger u_trigger (
		.iCLK(iCLK), .arst_n(arst_n), .button(button),
		.local_init_done(local_init_done), .start(start)
	);

	test_sequencer u_seq (
		.iCLK(iCLK), .arst_n(arst_n), .start(start), .pattern_seed(pattern_seed),
		.pattern(pattern), .match_valid(match_valid), .match(match),
		.avl_waitrequest_n(avl_waitrequest_n), .seed(seed), .address(avl_address),
		.avl_write(avl_write), .avl_read(avl_read), .avl_writedata(avl_writedata),
		.state(c_state), .fail_address(fail_address)
	);

	pattern_gen u_pattern (
		.iCLK(iCLK), .arst_n(arst_n), .seed(seed), .address(avl_address), .pattern(pattern)
	);

	readback_checker u_check (
		.iCLK(iCLK), .arst_n(arst_n), .avl_readdatavalid(avl_readdatavalid),
		.avl_readdata(avl_readdata), .pattern(pattern),
		.match_valid(match_valid), .match(match)
	);

	// ==============================
	// status
	// ==============================
	assign avl_burstbegin           = 1'b0; // no bursts
	assign drv_status_pass          = (c_state == mem_test_pkg::test_pass);
	assign drv_status_fail          = (c_state == mem_test_pkg::test_fail);
	assign drv_status_test_complete = drv_status_pass | drv_status_fail; // sticky via fsm

endmodule

//--- sequencer/test_sequencer.sv
`include "mem_test_defines.svh"

module test_sequencer (
	input  logic                            iCLK,
	input  logic                            arst_n,
	input  logic                            start,             // one cycle pulse from trigger
	input  logic [63:0]                     pattern_seed,      // seed chosen outside
	input  logic [mem_test_pkg::DATA_W-1:0] pattern,           // expected word for address
	input  logic                            match_valid,       // checker verdict strobe
	input  logic                            match,             // readback equals pattern
	input  logic                            avl_waitrequest_n, // high completes a request
	output logic [63:0]                     seed,              // seed held for the run
	output logic [`MT_ADDR_W-1:0]           address,           // also the avalon address
	output logic                            avl_write,
	output logic                            avl_read,
	output logic [mem_test_pkg::DATA_W-1:0] avl_writedata,
	output mem_test_pkg::test_state_e       state,
	output logic [`MT_ADDR_W-1:0]           fail_address       // first mismatching word
);

	// counter wide enough for the settle count and the turnaround
	localparam int               CNT_W       = $clog2(`MT_SETTLE_CYCLES) + 1;
	localparam logic [CNT_W-1:0] SETTLE_LAST = CNT_W'(`MT_SETTLE_CYCLES - 1);
	localparam logic [CNT_W-1:0] TURN_LAST   = CNT_W'(1); // two dead cycles

	logic [CNT_W-1:0] wait_cnt;    // settle and turnaround counter
	logic             settle_done; // pattern is valid for address
	logic             turn_done;   // turnaround over
	logic             last_addr;   // all ones address

	assign settle_done = (wait_cnt == SETTLE_LAST);
	assign turn_done   = (wait_cnt == TURN_LAST);
	assign last_addr   = &address;

	// ==============================
	// control fsm
	// ==============================
	always_ff @(posedge iCLK or negedge arst_n) begin
		if (!arst_n) begin
			state        <= mem_test_pkg::idle;
			wait_cnt     <= '0;
			address      <= '0;
			avl_write    <= 1'b0;
			avl_read     <= 1'b0;
			fail_address <= '0;
		end else begin
			case (state)
				mem_test_pkg::idle: begin
					address  <= '0; // sweep starts at word zero
					wait_cnt <= '0;
					if (start) begin
						state <= mem_test_pkg::write_setup;
					end
				end
				mem_test_pkg::write_setup: begin
					if (settle_done) begin
						wait_cnt  <= '0;
						avl_write <= 1'b1; // data loaded on the same edge
						state     <= mem_test_pkg::write_wait;
					end else begin
						wait_cnt <= wait_cnt + 1'b1;
					end
				end
				mem_test_pkg::write_wait: begin
					if (avl_waitrequest_n) begin
						avl_write <= 1'b0; // accepted this cycle
						state     <= mem_test_pkg::write_next;
					end
				end
				mem_test_pkg::write_next: begin
					if (last_addr) begin
						address <= '0; // rewind for read pass
						state   <= mem_test_pkg::turnaround;
					end else begin
						address <= address + 1'b1;
						state   <= mem_test_pkg::write_setup;
					end
				end
				mem_test_pkg::turnaround: begin
					if (turn_done) begin
						wait_cnt <= '0;
						state    <= mem_test_pkg::read_req;
					end else begin
						wait_cnt <= wait_cnt + 1'b1;
					end
				end
				mem_test_pkg::read_req: begin
					if (settle_done) begin
						wait_cnt <= '0;
						avl_read <= 1'b1; // pattern now matches address
						state    <= mem_test_pkg::read_wait;
					end else begin
						wait_cnt <= wait_cnt + 1'b1;
					end
				end
				mem_test_pkg::read_wait: begin
					if (avl_waitrequest_n) begin
						avl_read <= 1'b0;
						state    <= mem_test_pkg::compare;
					end
				end
				mem_test_pkg::compare: begin
					if (match_valid) begin // one read outstanding, so this is ours
						if (match) begin
							state <= mem_test_pkg::read_next;
						end else begin
							fail_address <= address; // first bad word
							state        <= mem_test_pkg::test_fail;
						end
					end
				end
				mem_test_pkg::read_next: begin
					if (last_addr) begin
						state <= mem_test_pkg::test_pass;
					end else begin
						address <= address + 1'b1;
						state   <= mem_test_pkg::read_req;
					end
				end
				mem_test_pkg::test_pass: state <= mem_test_pkg::test_pass; // sticky
				mem_test_pkg::test_fail: state <= mem_test_pkg::test_fail; // sticky
				default: state <= mem_test_pkg::idle;
			endcase
		end
	end

	// ==============================
	// payload
	// ==============================
	always_ff @(posedge iCLK) begin
		if (start && state == mem_test_pkg::idle) begin
			seed <= pattern_seed; // frozen for the whole run
		end
		if (state == mem_test_pkg::write_setup && settle_done) begin
			avl_writedata <= pattern; // held until the write is accepted
		end
	end

	// ==============================
	// protocol checks
	// ==============================
	a_no_rw_overlap: assert property (
		@(posedge iCLK) disable iff (!arst_n)
		!(avl_write && avl_read)
	) else $error("test_sequencer: write and read high together");

	// a stalled write keeps request, address and data
	a_write_held: assert property (
		@(posedge iCLK) disable iff (!arst_n)
		avl_write && !avl_waitrequest_n |=>
			avl_write && $stable(address) && $stable(avl_writedata)
	) else $error("test_sequencer: write changed while waitrequest held it");

	// a stalled read keeps request and address
	a_read_held: assert property (
		@(posedge iCLK) disable iff (!arst_n)
		avl_read && !avl_waitrequest_n |=> avl_read && $stable(address)
	) else $error("test_sequencer: read changed while waitrequest held it");

endmodule

//--- src/readback_checker.sv
module readback_checker (
	input  logic                            iCLK,
	input  logic                            arst_n,
	input  logic                            avl_readdatavalid, // one strobe per accepted read
	input  logic [mem_test_pkg::DATA_W-1:0] avl_readdata,      // returned word
	input  logic [mem_test_pkg::DATA_W-1:0] pattern,           // expected word, held by sequencer
	output logic                            match_valid,       // verdict strobe
	output logic                            match              // valid with match_valid
);

	logic [mem_test_pkg::DATA_W-1:0] data_q; // captured read data

	// ==============================
	// capture
	// ==============================
	always_ff @(posedge iCLK) begin
		if (avl_readdatavalid) begin
			data_q <= avl_readdata; // only on the strobe
		end
	end

	always_ff @(posedge iCLK or negedge arst_n) begin
		if (!arst_n) begin
			match_valid <= 1'b0;
		end else begin
			match_valid <= avl_readdatavalid; // verdict one cycle after data
		end
	end

	// ==============================
	// compare
	// ==============================
	// address is frozen during the read, so pattern has long settled
	assign match = (data_q == pattern); // full 128 bit compare

	// ==============================
	// checks
	// ==============================
	// the verdict is never built from unknown bits
	a_verdict_known: assert property (
		@(posedge iCLK) disable iff (!arst_n)
		match_valid |-> !$isunknown(match)
	) else $error("readback_checker: verdict on unknown read data or pattern");

	// single outstanding read means no back to back returns
	a_single_return: assert property (
		@(posedge iCLK) disable iff (!arst_n)
		avl_readdatavalid |=> !avl_readdatavalid
	) else $error("readback_checker: read data returned on consecutive cycles");

endmodule

//--- sequencer/pattern_gen.sv
`include "mem_test_defines.svh"

module pattern_gen (
	input  logic                            iCLK,
	input  logic                            arst_n,
	input  logic [63:0]                     seed,    // captured by sequencer on start
	input  logic [`MT_ADDR_W-1:0]           address, // word address under test
	output logic [mem_test_pkg::DATA_W-1:0] pattern  // word for address of two cycles ago
);

	logic [63:0] mix;    // seed plus address
	logic [63:0] rot;    // halves swapped, seed folded in
	logic [63:0] rot_q;  // step one result
	logic [63:0] seed_q; // seed aligned with rot_q
	logic [63:0] sum;    // rot plus seed
	logic [7:0]  tag;    // low byte checksum

	// ==============================
	// step one
	// ==============================
	assign mix = seed + {{(64 - `MT_ADDR_W){1'b0}}, address}; // zero extended, wraps mod 2^64
	assign rot = {mix[31:0], mix[63:32]} ^ seed;

	always_ff @(posedge iCLK or negedge arst_n) begin
		if (!arst_n) begin
			rot_q  <= '0;
			seed_q <= '0;
		end else begin
			rot_q  <= rot;
			seed_q <= seed; // keeps both steps on the same seed
		end
	end

	// ==============================
	// step two
	// ==============================
	assign sum = rot_q + seed_q;
	assign tag = rot_q[7:0] + sum[7:0]; // mod 256

	always_ff @(posedge iCLK or negedge arst_n) begin
		if (!arst_n) begin
			pattern <= '0;
		end else begin
			pattern <= {sum[61:6], tag, sum}; // 56 + 8 + 64 bits
		end
	end

endmodule

//--- src/start_trigger.sv
module start_trigger (
	input  logic iCLK,
	input  logic arst_n,
	input  logic button,          // raw push button, low when pressed
	input  logic local_init_done, // controller calibration finished
	output logic start            // one cycle start request
);

	logic btn_meta; // first sync stage
	logic btn_sync; // second sync stage, safe to use
	logic btn_prev; // last synced level for edge detect
	logic btn_fall; // high for one cycle on press

	// ==============================
	// edge detect
	// ==============================
	assign btn_fall = btn_prev & ~btn_sync; // high then low

	// ==============================
	// sync and gate
	// ==============================
	// the button idles high, so all stages come out of reset high
	// and a button held through reset does not fire
	always_ff @(posedge iCLK or negedge arst_n) begin
		if (!arst_n) begin
			btn_meta <= 1'b1;
			btn_sync <= 1'b1;
			btn_prev <= 1'b1;
			start    <= 1'b0;
		end else begin
			btn_meta <= button;    // async capture
			btn_sync <= btn_meta;  // metastability settle
			btn_prev <= btn_sync;  // one cycle history
			start    <= btn_fall & local_init_done; // no start before init
		end
	end

endmodule

//--- common/mem_test_pkg.sv
package mem_test_pkg;

	// ==============================
	// bus geometry
	// ==============================
	// the pattern layout fills exactly 56 + 8 + 64 bits
	localparam int DATA_W = 128; // avalon data width

	// ==============================
	// tester fsm
	// ==============================
	typedef enum logic [3:0] {
		idle        = 4'd0,  // waiting for start pulse
		write_setup = 4'd1,  // settle count before a write
		write_wait  = 4'd2,  // write held until accepted
		write_next  = 4'd3,  // step address or leave write pass
		turnaround  = 4'd4,  // two dead cycles between passes
		read_req    = 4'd5,  // settle count before a read
		read_wait   = 4'd6,  // read held until accepted
		compare     = 4'd7,  // waiting for checker verdict
		read_next   = 4'd8,  // step address or finish
		test_pass   = 4'd9,  // sticky, all words matched
		test_fail   = 4'd10  // sticky, first mismatch seen
	} test_state_e;

	// encodings 11 to 15 are unused and fall back to idle

	// one run walks
	//   idle -> write pass -> turnaround -> read pass -> pass or fail
	// and never leaves the last state until reset

endpackage

//--- common/mem_test_defines.svh
`ifndef MEM_TEST_DEFINES_SVH
`define MEM_TEST_DEFINES_SVH

// ==============================
// address space
// ==============================
// word address width, 6 gives a 64 word sweep
`define MT_ADDR_W 6 // 26 covers the full ddr part

// ==============================
// pattern timing
// ==============================
// cycles held after an address change before the pattern is used
`define MT_SETTLE_CYCLES 9 // pattern_gen latency is 2, so never below 2

// both are word counts, not byte counts

`endif
